//--- source/dcache_pkg.sv
// shared constants, enums and structs for the data cache, referenced by scoped name
`default_nettype none

package dcache_pkg;

  // word address split: tag | set | offset
  localparam int ADDR_BITS = 16;
  localparam int OFFSET_BITS = 2;
  localparam int SET_BITS = 3;
  localparam int TAG_BITS = ADDR_BITS - SET_BITS - OFFSET_BITS;
  localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;
  localparam int WORD_BITS = 32;

  // derived counts
  localparam int LINE_WORDS = 1 << OFFSET_BITS;
  localparam int NUM_SETS = 1 << SET_BITS;

  // four words per line, word 0 in the low bits
  typedef logic [LINE_WORDS-1:0][WORD_BITS-1:0] line_t;

  typedef enum logic {
    OP_LOAD,
    OP_STORE
  } cache_op_e;

  // processor request, 49 bits
  typedef struct packed {
    cache_op_e op;
    logic [ADDR_BITS-1:0] addr;
    logic [WORD_BITS-1:0] wdata;
  } cpu_req_t;

  // processor response, hit means hit on first lookup
  typedef struct packed {
    logic [WORD_BITS-1:0] rdata;
    logic hit;
  } cpu_resp_t;

  // line-wide memory command, 143 bits
  typedef struct packed {
    logic write;
    logic [LINE_ADDR_BITS-1:0] line_addr;
    line_t wline;
  } mem_cmd_t;

  typedef struct packed {
    cache_op_e op;
    logic [TAG_BITS-1:0] tag;
    logic [SET_BITS-1:0] set;
    logic [OFFSET_BITS-1:0] offset;
    logic [WORD_BITS-1:0] wdata;
  } decoded_req_t;

  // one way's entry for the addressed set
  typedef struct packed {
    logic valid;
    logic dirty;
    logic [TAG_BITS-1:0] tag;
    line_t line;
  } way_view_t;

  // write bundle shared by all ways, gated per way by a select bit
  typedef struct packed {
    logic line_we;
    logic word_we;
    logic [SET_BITS-1:0] set;
    logic [TAG_BITS-1:0] tag;
    logic [OFFSET_BITS-1:0] offset;
    logic [WORD_BITS-1:0] word;
    line_t line;
    logic dirty;
  } way_write_t;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    WRITEBACK,
    REFILL,
    RESPOND,
    RELEASE
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- source/dcache_req_decode.sv
// request capture stage, registers one processor request and splits its word address
`default_nettype none
`timescale 1ns/100ps

module dcache_req_decode (
  input logic clock,
  input logic reset,
  input logic cpu_req,
  input dcache_pkg::cpu_req_t cpu_req_data,
  input logic busy,
  output logic dec_valid,
  output dcache_pkg::decoded_req_t dec_req
);

  logic capture;

  // busy covers the whole access, so a held req is not taken twice
  assign capture = cpu_req && !busy;

  // one-cycle pulse after the capture edge
  always_ff @(posedge clock) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= capture;
    end
  end

  // payload held until the next capture
  always_ff @(posedge clock) begin
    if (capture) begin
      dec_req.op <= cpu_req_data.op;
      dec_req.wdata <= cpu_req_data.wdata;
      // offset in the low bits
      dec_req.offset <= cpu_req_data.addr[dcache_pkg::OFFSET_BITS-1:0];
      // set index above it
      dec_req.set <= cpu_req_data.addr[dcache_pkg::OFFSET_BITS +: dcache_pkg::SET_BITS];
      // tag is whatever is left at the top
      dec_req.tag <= cpu_req_data.addr[dcache_pkg::ADDR_BITS-1 -: dcache_pkg::TAG_BITS];
    end
  end

endmodule

`default_nettype wire

//--- source/dcache_way.sv
// one cache way: tag, valid, dirty and line arrays with a combinational view of one set
`default_nettype none
`timescale 1ns/100ps

module dcache_way (
  input logic clock,
  input logic reset,
  input logic [dcache_pkg::SET_BITS-1:0] set,
  input dcache_pkg::way_write_t wr,
  input logic we,
  output dcache_pkg::way_view_t view
);

  // per-set storage
  logic [dcache_pkg::TAG_BITS-1:0] tags [dcache_pkg::NUM_SETS];
  dcache_pkg::line_t lines [dcache_pkg::NUM_SETS];
  logic [dcache_pkg::NUM_SETS-1:0] valid;
  logic [dcache_pkg::NUM_SETS-1:0] dirty;

  // read side, no register
  always_comb begin
    view.valid = valid[set];
    view.dirty = dirty[set];
    view.tag = tags[set];
    view.line = lines[set];
  end

  // status bits
  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
      dirty <= '0;
    end else if (we && wr.line_we) begin
      // fill installs a fresh line
      valid[wr.set] <= 1'b1;
      dirty[wr.set] <= wr.dirty;
    end else if (we && wr.word_we) begin
      // store hit
      dirty[wr.set] <= 1'b1;
    end
  end

  // tag and data arrays
  always_ff @(posedge clock) begin
    if (we && wr.line_we) begin
      tags[wr.set] <= wr.tag;
      lines[wr.set] <= wr.line;
    end else if (we && wr.word_we) begin
      // single word replace, tag unchanged
      lines[wr.set][wr.offset] <= wr.word;
    end
  end

endmodule

`default_nettype wire

//--- source/dcache_lru.sv
// true-LRU state: per-set recency list of way numbers, most recent at position 0
`default_nettype none
`timescale 1ns/100ps

module dcache_lru #(
  parameter int NUM_WAYS = 4
) (
  input logic clock,
  input logic reset,
  input logic touch,
  input logic [dcache_pkg::SET_BITS-1:0] touch_set,
  input logic [$clog2(NUM_WAYS)-1:0] touch_way,
  input logic [dcache_pkg::SET_BITS-1:0] query_set,
  output logic [$clog2(NUM_WAYS)-1:0] victim
);

  localparam int WAY_BITS = $clog2(NUM_WAYS);

  // order[s][0] most recent, order[s][NUM_WAYS-1] least recent
  logic [NUM_WAYS-1:0][WAY_BITS-1:0] order [dcache_pkg::NUM_SETS];
  // entry i takes entry i-1 when the touched way sits at or behind i
  logic [NUM_WAYS-1:1] shift;

  always_comb begin : find_pos
    logic seen;
    seen = (order[touch_set][0] == touch_way);
    for (int i = 1; i < NUM_WAYS; i++) begin
      shift[i] = !seen;
      if (order[touch_set][i] == touch_way) begin
        seen = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      // 0, 1 .. NUM_WAYS-1 in every set
      for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
        for (int i = 0; i < NUM_WAYS; i++) begin
          order[s][i] <= WAY_BITS'(i);
        end
      end
    end else if (touch) begin
      // move to front, entries ahead of it slide back one
      order[touch_set][0] <= touch_way;
      for (int i = 1; i < NUM_WAYS; i++) begin
        if (shift[i]) begin
          order[touch_set][i] <= order[touch_set][i-1];
        end
      end
    end
  end

  // tail of the list
  assign victim = order[query_set][NUM_WAYS-1];

endmodule

`default_nettype wire

//--- source/dcache_ctrl.sv
// cache control: hit merge, miss FSM with write-back and refill, processor and memory handshakes
`default_nettype none
`timescale 1ns/100ps

module dcache_ctrl #(
  parameter int NUM_WAYS = 4
) (
  input logic clock,
  input logic reset,
  input logic dec_valid,
  input dcache_pkg::decoded_req_t dec_req,
  input dcache_pkg::way_view_t views [NUM_WAYS],
  input logic [$clog2(NUM_WAYS)-1:0] victim,
  output logic busy,
  output dcache_pkg::way_write_t way_wr,
  output logic [NUM_WAYS-1:0] way_we,
  output logic lru_touch,
  output logic [dcache_pkg::SET_BITS-1:0] lru_set,
  output logic [$clog2(NUM_WAYS)-1:0] lru_way,
  input logic cpu_req,
  output logic cpu_ack,
  output dcache_pkg::cpu_resp_t cpu_resp,
  output logic mem_req,
  input logic mem_ack,
  output dcache_pkg::mem_cmd_t mem_cmd,
  input dcache_pkg::line_t mem_rdata
);

  localparam int WAY_BITS = $clog2(NUM_WAYS);

  dcache_pkg::ctrl_state_e state;
  logic [NUM_WAYS-1:0] hit_vec;
  logic hit;
  logic [WAY_BITS-1:0] hit_way;
  logic [WAY_BITS-1:0] vic_way;
  logic is_store;
  logic fill_done;
  logic [dcache_pkg::WORD_BITS-1:0] hit_word;
  dcache_pkg::way_view_t vic_view;
  dcache_pkg::line_t fill_line;
  dcache_pkg::mem_cmd_t wb_cmd;
  dcache_pkg::mem_cmd_t rf_cmd;

  // decode holds dec_valid for one cycle while state is still IDLE
  assign busy = (state != dcache_pkg::IDLE) || dec_valid;
  assign is_store = (dec_req.op == dcache_pkg::OP_STORE);

  // tag compare per way, lowest way wins
  always_comb begin
    hit_way = '0;
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      hit_vec[w] = views[w].valid && (views[w].tag == dec_req.tag);
      if (hit_vec[w]) begin
        hit_way = WAY_BITS'(w);
      end
    end
  end
  assign hit = |hit_vec;
  assign hit_word = views[hit_way].line[dec_req.offset];

  // LRU tail of the set under lookup
  assign vic_view = views[victim];

  // memory line with the store word merged in
  always_comb begin
    fill_line = mem_rdata;
    if (is_store) begin
      fill_line[dec_req.offset] = dec_req.wdata;
    end
  end
  assign fill_done = (state == dcache_pkg::REFILL) && mem_req && mem_ack;

  // victim goes back under its own tag
  always_comb begin
    wb_cmd.write = 1'b1;
    wb_cmd.line_addr = {vic_view.tag, dec_req.set};
    wb_cmd.wline = vic_view.line;
    rf_cmd.write = 1'b0;
    rf_cmd.line_addr = {dec_req.tag, dec_req.set};
    rf_cmd.wline = '0;
  end

  // way writes: store hit word, or refill line into the victim way
  always_comb begin
    way_wr.line_we = fill_done;
    way_wr.word_we = (state == dcache_pkg::LOOKUP) && hit && is_store;
    way_wr.set = dec_req.set;
    way_wr.tag = dec_req.tag;
    way_wr.offset = dec_req.offset;
    way_wr.word = dec_req.wdata;
    way_wr.line = fill_line;
    // store fill is dirty, load fill clean
    way_wr.dirty = is_store;
    way_we = '0;
    way_we[fill_done ? vic_way : hit_way] = way_wr.line_we || way_wr.word_we;
  end

  // touch on the edge the response goes out
  assign lru_touch = fill_done || ((state == dcache_pkg::LOOKUP) && hit);
  assign lru_way = fill_done ? vic_way : hit_way;
  assign lru_set = dec_req.set;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= dcache_pkg::IDLE;
      cpu_ack <= 1'b0;
      mem_req <= 1'b0;
    end else begin
      case (state)
        dcache_pkg::IDLE: begin
          if (dec_valid) begin
            state <= dcache_pkg::LOOKUP;
          end
        end
        dcache_pkg::LOOKUP: begin
          if (hit) begin
            cpu_ack <= 1'b1;
            state <= dcache_pkg::RESPOND;
          end else begin
            // write-back first only for a dirty valid victim
            mem_req <= 1'b1;
            state <= (vic_view.valid && vic_view.dirty) ? dcache_pkg::WRITEBACK
                                                        : dcache_pkg::REFILL;
          end
        end
        dcache_pkg::WRITEBACK: begin
          if (mem_req && mem_ack) begin
            mem_req <= 1'b0;
          end else if (!mem_req && !mem_ack) begin
            // write done and ack gone, start the read
            mem_req <= 1'b1;
            state <= dcache_pkg::REFILL;
          end
        end
        dcache_pkg::REFILL: begin
          if (fill_done) begin
            mem_req <= 1'b0;
            cpu_ack <= 1'b1;
            state <= dcache_pkg::RESPOND;
          end
        end
        dcache_pkg::RESPOND: begin
          // ack held until the processor lets go
          if (!cpu_req) begin
            cpu_ack <= 1'b0;
            state <= dcache_pkg::RELEASE;
          end
        end
        dcache_pkg::RELEASE: begin
          if (!mem_ack) begin
            state <= dcache_pkg::IDLE;
          end
        end
        default: state <= dcache_pkg::IDLE;
      endcase
    end
  end

  // response, command and victim registers
  always_ff @(posedge clock) begin
    if (state == dcache_pkg::LOOKUP) begin
      vic_way <= victim;
      if (hit) begin
        cpu_resp.rdata <= is_store ? dec_req.wdata : hit_word;
        cpu_resp.hit <= 1'b1;
      end else begin
        mem_cmd <= (vic_view.valid && vic_view.dirty) ? wb_cmd : rf_cmd;
      end
    end
    if ((state == dcache_pkg::WRITEBACK) && !mem_req && !mem_ack) begin
      mem_cmd <= rf_cmd;
    end
    if (fill_done) begin
      // word after the access, store data for a store
      cpu_resp.rdata <= fill_line[dec_req.offset];
      cpu_resp.hit <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- source/dcache_top.sv
// data cache top level, sets the way count and wires decode, ways, LRU and control together
`default_nettype none
`timescale 1ns/100ps

module dcache_top #(
  parameter int NUM_WAYS = 4
) (
  input logic clock,
  input logic reset,
  input logic cpu_req,
  output logic cpu_ack,
  input dcache_pkg::cpu_req_t cpu_req_data,
  output dcache_pkg::cpu_resp_t cpu_resp,
  output logic mem_req,
  input logic mem_ack,
  output dcache_pkg::mem_cmd_t mem_cmd,
  input dcache_pkg::line_t mem_rdata
);

  logic dec_valid;
  logic busy;
  dcache_pkg::decoded_req_t dec_req;
  dcache_pkg::way_view_t views [NUM_WAYS];
  dcache_pkg::way_write_t way_wr;
  logic [NUM_WAYS-1:0] way_we;
  logic lru_touch;
  logic [dcache_pkg::SET_BITS-1:0] lru_set;
  logic [$clog2(NUM_WAYS)-1:0] lru_way;
  logic [$clog2(NUM_WAYS)-1:0] victim;

  dcache_req_decode u_decode (
    .clock(clock),
    .reset(reset),
    .cpu_req(cpu_req),
    .cpu_req_data(cpu_req_data),
    .busy(busy),
    .dec_valid(dec_valid),
    .dec_req(dec_req)
  );

  // all ways look at the captured set
  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    dcache_way u_way (
      .clock(clock),
      .reset(reset),
      .set(dec_req.set),
      .wr(way_wr),
      .we(way_we[w]),
      .view(views[w])
    );
  end

  dcache_lru #(
    .NUM_WAYS(NUM_WAYS)
  ) u_lru (
    .clock(clock),
    .reset(reset),
    .touch(lru_touch),
    .touch_set(lru_set),
    .touch_way(lru_way),
    .query_set(dec_req.set),
    .victim(victim)
  );

  dcache_ctrl #(
    .NUM_WAYS(NUM_WAYS)
  ) u_ctrl (
    .clock(clock),
    .reset(reset),
    .dec_valid(dec_valid),
    .dec_req(dec_req),
    .views(views),
    .victim(victim),
    .busy(busy),
    .way_wr(way_wr),
    .way_we(way_we),
    .lru_touch(lru_touch),
    .lru_set(lru_set),
    .lru_way(lru_way),
    .cpu_req(cpu_req),
    .cpu_ack(cpu_ack),
    .cpu_resp(cpu_resp),
    .mem_req(mem_req),
    .mem_ack(mem_ack),
    .mem_cmd(mem_cmd),
    .mem_rdata(mem_rdata)
  );

endmodule

`default_nettype wire

//--- testbench/dcache_assert.sv
// handshake assertions for the data cache, bound into the top level from the testbench
`default_nettype none
`timescale 1ns/100ps

module dcache_assert (
  input logic clock,
  input logic reset,
  input logic cpu_req,
  input logic cpu_ack,
  input logic mem_req,
  input logic mem_ack,
  input dcache_pkg::mem_cmd_t mem_cmd
);

  // ack cleared once reset has been seen for an edge
  ack_low_in_reset: assert property (@(posedge clock) reset && $past(reset) |-> !cpu_ack)
    else $error("cpu_ack high during reset");

  // response held until the processor lets go
  ack_held: assert property (@(posedge clock) disable iff (reset) cpu_ack && cpu_req |=> cpu_ack)
    else $error("cpu_ack dropped while cpu_req was high");

  mem_req_held: assert property (@(posedge clock) disable iff (reset)
    mem_req && !mem_ack |=> mem_req)
    else $error("mem_req dropped before mem_ack");

  // command frozen for the whole request
  mem_cmd_stable: assert property (@(posedge clock) disable iff (reset)
    mem_req && $past(mem_req) |-> mem_cmd == $past(mem_cmd))
    else $error("mem_cmd changed while mem_req was high");

endmodule

`default_nettype wire

//--- testbench/dcache_tb.sv
// data cache testbench, directed and seeded random accesses checked against a reference cache model
`default_nettype none
`timescale 1ns/100ps

module dcache_tb;

  localparam int NUM_WAYS = 4;
  localparam int NUM_RANDOM = 400;
  // worst miss with write-back and slow memory stays well inside this
  localparam int CYCLES_PER_ACCESS = 40;
  localparam int TIMEOUT_CYCLES = NUM_RANDOM * CYCLES_PER_ACCESS;
  localparam int unsigned SEED = 32'hbee4a0f9;

  logic clock;
  logic reset;
  logic cpu_req;
  logic cpu_ack;
  dcache_pkg::cpu_req_t cpu_req_data;
  dcache_pkg::cpu_resp_t cpu_resp;
  logic mem_req;
  logic mem_ack;
  dcache_pkg::mem_cmd_t mem_cmd;
  dcache_pkg::line_t mem_rdata;

  int mismatches = 0;
  int failures = 0;
  int accesses = 0;
  int cycles = 0;
  logic prev_ack = 1'b0;
  logic prev_req = 1'b0;

  // backing memory, only written lines are stored
  dcache_pkg::line_t backing [logic [dcache_pkg::LINE_ADDR_BITS-1:0]];
  // memory traffic the model expects for the access in flight
  dcache_pkg::mem_cmd_t exp_wb [$];
  logic [dcache_pkg::LINE_ADDR_BITS-1:0] exp_rf [$];

  // reference cache state
  logic m_valid [dcache_pkg::NUM_SETS][NUM_WAYS];
  logic m_dirty [dcache_pkg::NUM_SETS][NUM_WAYS];
  logic [dcache_pkg::TAG_BITS-1:0] m_tag [dcache_pkg::NUM_SETS][NUM_WAYS];
  dcache_pkg::line_t m_line [dcache_pkg::NUM_SETS][NUM_WAYS];
  // recency list, position 0 most recent
  int m_order [dcache_pkg::NUM_SETS][NUM_WAYS];

  dcache_top #(
    .NUM_WAYS(NUM_WAYS)
  ) dut0 (
    .clock(clock),
    .reset(reset),
    .cpu_req(cpu_req),
    .cpu_ack(cpu_ack),
    .cpu_req_data(cpu_req_data),
    .cpu_resp(cpu_resp),
    .mem_req(mem_req),
    .mem_ack(mem_ack),
    .mem_cmd(mem_cmd),
    .mem_rdata(mem_rdata)
  );

  bind dcache_top dcache_assert u_assert (
    .clock(clock),
    .reset(reset),
    .cpu_req(cpu_req),
    .cpu_ack(cpu_ack),
    .mem_req(mem_req),
    .mem_ack(mem_ack),
    .mem_cmd(mem_cmd)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // unwritten memory, every word carries its full word address
  function automatic dcache_pkg::line_t fill_pattern(logic [13:0] la);
    dcache_pkg::line_t l;
    for (int w = 0; w < dcache_pkg::LINE_WORDS; w++) begin
      l[w] = {14'b0, la, 2'(w), 2'b01} ^ {la, 2'(w), 16'hc3a5};
    end
    return l;
  endfunction

  function automatic dcache_pkg::line_t backing_line(logic [13:0] la);
    if (backing.exists(la)) begin
      return backing[la];
    end
    return fill_pattern(la);
  endfunction

  function automatic logic [15:0] make_addr(int tag, int set, int off);
    return {11'(tag), 3'(set), 2'(off)};
  endfunction

  // named way to the front, the ones ahead of it slide back
  function automatic void touch_model(int s, int way);
    int pos;
    pos = 0;
    for (int i = 0; i < NUM_WAYS; i++) begin
      if (m_order[s][i] == way) pos = i;
    end
    for (int i = pos; i > 0; i--) begin
      m_order[s][i] = m_order[s][i-1];
    end
    m_order[s][0] = way;
  endfunction

  function automatic void model_access(input dcache_pkg::cache_op_e op, input logic [15:0] addr,
                                       input logic [31:0] wdata, output logic hit,
                                       output logic [31:0] rdata);
    int s;
    int off;
    int way;
    logic [10:0] tag;
    dcache_pkg::mem_cmd_t wb;
    s = int'(addr[4:2]);
    off = int'(addr[1:0]);
    tag = addr[15:5];
    hit = 1'b0;
    way = 0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (!hit && m_valid[s][w] && (m_tag[s][w] == tag)) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      // victim is the tail, written back only if dirty
      way = m_order[s][NUM_WAYS-1];
      if (m_valid[s][way] && m_dirty[s][way]) begin
        wb.write = 1'b1;
        wb.line_addr = {m_tag[s][way], 3'(s)};
        wb.wline = m_line[s][way];
        exp_wb.push_back(wb);
      end
      exp_rf.push_back(addr[15:2]);
      m_line[s][way] = backing_line(addr[15:2]);
      m_tag[s][way] = tag;
      m_valid[s][way] = 1'b1;
      m_dirty[s][way] = 1'b0;
    end
    if (op == dcache_pkg::OP_STORE) begin
      m_line[s][way][off] = wdata;
      m_dirty[s][way] = 1'b1;
    end
    rdata = m_line[s][way][off];
    touch_model(s, way);
  endfunction

  task automatic end_run();
    $display("errors: %0d mismatches, %0d other failures after %0d accesses",
             mismatches, failures, accesses);
    if ((mismatches == 0) && (failures == 0)) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  endtask

  // one processor access, idle cycles before req, hold cycles before req drops
  task automatic access(input dcache_pkg::cache_op_e op, input logic [15:0] addr,
                        input logic [31:0] wdata, input int idle, input int hold,
                        input bit check_latency);
    logic exp_hit;
    logic [31:0] exp_data;
    int waited;
    model_access(op, addr, wdata, exp_hit, exp_data);
    repeat (idle) @(negedge clock);
    cpu_req_data.op = op;
    cpu_req_data.addr = addr;
    cpu_req_data.wdata = wdata;
    cpu_req = 1'b1;
    waited = 0;
    do begin
      @(negedge clock);
      waited++;
    end while (!cpu_ack);
    // capture edge, then ack two edges later
    if (check_latency) begin
      assert (waited == 3) else begin
        failures++;
        $display("hit ack for address %h came %0d cycles after req instead of 3", addr, waited);
      end
    end
    assert (cpu_resp.hit == exp_hit) else begin
      mismatches++;
      $display("MISMATCH cpu_resp.hit addr %h: got %h expected %h", addr, cpu_resp.hit, exp_hit);
    end
    assert (cpu_resp.rdata == exp_data) else begin
      mismatches++;
      $display("MISMATCH cpu_resp.rdata addr %h: got %h expected %h",
               addr, cpu_resp.rdata, exp_data);
    end
    repeat (hold) @(negedge clock);
    cpu_req = 1'b0;
    do @(negedge clock); while (cpu_ack);
    assert ((exp_wb.size() == 0) && (exp_rf.size() == 0)) else begin
      failures++;
      $display("access to %h finished without its expected write-back or refill", addr);
      exp_wb.delete();
      exp_rf.delete();
    end
    accesses++;
  endtask

  // memory responder, random delay then ack until req drops
  initial begin
    dcache_pkg::mem_cmd_t wb;
    mem_ack = 1'b0;
    mem_rdata = '0;
    forever begin
      @(negedge clock);
      if (mem_req && !mem_ack) begin
        repeat ($urandom_range(0, 5)) @(negedge clock);
        if (mem_cmd.write) begin
          assert (exp_wb.size() != 0) else begin
            failures++;
            $display("unexpected memory write to line %h", mem_cmd.line_addr);
          end
          if (exp_wb.size() != 0) begin
            wb = exp_wb.pop_front();
            assert (mem_cmd.line_addr == wb.line_addr) else begin
              mismatches++;
              $display("MISMATCH mem_cmd.line_addr: got %h expected %h",
                       mem_cmd.line_addr, wb.line_addr);
            end
            assert (mem_cmd.wline == wb.wline) else begin
              mismatches++;
              $display("MISMATCH mem_cmd.wline: got %h expected %h", mem_cmd.wline, wb.wline);
            end
          end
          backing[mem_cmd.line_addr] = mem_cmd.wline;
        end else begin
          assert ((exp_wb.size() == 0) && (exp_rf.size() != 0)) else begin
            failures++;
            $display("refill read of line %h out of order or not expected", mem_cmd.line_addr);
          end
          if (exp_rf.size() != 0) begin
            assert (mem_cmd.line_addr == exp_rf[0]) else begin
              mismatches++;
              $display("MISMATCH mem_cmd.line_addr: got %h expected %h",
                       mem_cmd.line_addr, exp_rf[0]);
            end
            void'(exp_rf.pop_front());
          end
          mem_rdata = backing_line(mem_cmd.line_addr);
        end
        mem_ack = 1'b1;
        do @(negedge clock); while (mem_req);
        mem_ack = 1'b0;
      end
    end
  end

  // handshake order, sampled values from the edge before
  always @(posedge clock) begin
    if (!reset) begin
      if (cpu_ack && !prev_ack) begin
        assert (prev_req) else begin
          failures++;
          $display("cpu_ack rose while cpu_req was low");
        end
      end
      if (!cpu_ack && prev_ack) begin
        assert (!prev_req) else begin
          failures++;
          $display("cpu_ack fell while cpu_req was still high");
        end
      end
    end
    prev_ack <= cpu_ack;
    prev_req <= cpu_req;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      failures++;
      $display("timeout, run went past %0d cycles", TIMEOUT_CYCLES);
      end_run();
    end
  end

  initial begin
    logic [15:0] addr;
    int r;
    void'($urandom(SEED));
    reset = 1'b1;
    cpu_req = 1'b0;
    cpu_req_data = '0;
    for (int s = 0; s < dcache_pkg::NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_valid[s][w] = 1'b0;
        m_dirty[s][w] = 1'b0;
        m_tag[s][w] = '0;
        m_line[s][w] = '0;
        m_order[s][w] = w;
      end
    end
    repeat (16) @(negedge clock);
    reset = 1'b0;

    // cold miss, then the same word hits at fixed latency
    access(dcache_pkg::OP_LOAD, 16'h0123, 32'h0, 2, 0, 1'b0);
    access(dcache_pkg::OP_LOAD, 16'h0123, 32'h0, 2, 0, 1'b1);

    // store miss merges into refill, store to a present line hits
    access(dcache_pkg::OP_STORE, 16'h0440, 32'hdead_beef, 2, 1, 1'b0);
    access(dcache_pkg::OP_LOAD, 16'h0440, 32'h0, 2, 0, 1'b1);
    access(dcache_pkg::OP_STORE, 16'h0441, 32'h1234_5678, 2, 0, 1'b1);
    access(dcache_pkg::OP_LOAD, 16'h0441, 32'h0, 1, 0, 1'b0);

    // five tags in set 3, LRU eviction
    for (int t = 1; t <= 5; t++) begin
      access(dcache_pkg::OP_LOAD, make_addr(t, 3, t % 4), 32'h0, 1, 0, 1'b0);
    end
    access(dcache_pkg::OP_LOAD, make_addr(2, 3, 0), 32'h0, 1, 0, 1'b0);
    access(dcache_pkg::OP_LOAD, make_addr(1, 3, 0), 32'h0, 1, 0, 1'b0);
    access(dcache_pkg::OP_LOAD, make_addr(3, 3, 1), 32'h0, 1, 0, 1'b0);

    // dirty lines in set 5, fifth tag forces a write-back
    for (int t = 10; t < 14; t++) begin
      access(dcache_pkg::OP_STORE, make_addr(t, 5, t % 4), 32'h5a00_0000 + t, 1, 0, 1'b0);
    end
    access(dcache_pkg::OP_LOAD, make_addr(14, 5, 0), 32'h0, 1, 0, 1'b0);
    // clean victims in set 6
    for (int t = 20; t < 25; t++) begin
      access(dcache_pkg::OP_LOAD, make_addr(t, 6, 2), 32'h0, 1, 0, 1'b0);
    end
    // evicted dirty data comes back from memory
    access(dcache_pkg::OP_LOAD, make_addr(10, 5, 2), 32'h0, 1, 0, 1'b0);

    // random mix over 64 lines, 8 tags per set
    for (int i = 0; i < NUM_RANDOM; i++) begin
      r = $urandom_range(0, 63);
      addr = make_addr((r >> 3) * 97, r % 8, $urandom_range(0, 3));
      access($urandom_range(0, 1) ? dcache_pkg::OP_STORE : dcache_pkg::OP_LOAD, addr,
             $urandom, $urandom_range(0, 2), $urandom_range(0, 3), 1'b0);
    end
    end_run();
  end

endmodule

`default_nettype wire

//--- vlog.f
source/dcache_pkg.sv
source/dcache_req_decode.sv
source/dcache_way.sv
source/dcache_lru.sv
source/dcache_ctrl.sv
source/dcache_top.sv
testbench/dcache_assert.sv
testbench/dcache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP := dcache_tb
FILELIST := vlog.f
BUILD_DIR := obj_dir
LOG := sim.log
SIM_FLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then \
		echo "simulation did not pass, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
